//--- hw/ramPkg.sv
package ramPkg;

	// ------------------------------
	// Widths
	// ------------------------------
	localparam int laneCount = 2;
	localparam int laneWidth = 8;
	localparam int ramAdrsWidth = 23;
	localparam int axiAdrsWidth = 8;
	localparam int axiDataWidth = 32;

	typedef logic [ramAdrsWidth-1:0] ramAdrs_t;
	typedef logic [laneCount*laneWidth-1:0] ramWord_t;
	typedef logic [laneWidth-1:0] ramByte_t;
	typedef logic [7:0] clkDiv_t;
	typedef logic [axiAdrsWidth-1:0] axiAdrs_t;
	typedef logic [axiDataWidth-1:0] axiData_t;
	typedef logic [1:0] axiResp_t;

	// PSRAM command codes
	localparam ramByte_t cmdWrite = 8'h38;
	localparam ramByte_t cmdRead = 8'hEB;
	// Address goes out as 24 bits, 3 bytes
	localparam int adrsBytes = 3;
	// Command, address and data byte of a write frame
	localparam int frameBytes = 5;
	localparam int readWaitClks = 4;
	localparam clkDiv_t clkDivReset = 8'd1;

	// ------------------------------
	// Register map
	// ------------------------------
	localparam axiAdrs_t regCtrl = 8'h00;
	localparam axiAdrs_t regAdrs = 8'h04;
	localparam axiAdrs_t regWdata = 8'h08;
	localparam axiAdrs_t regRdata = 8'h0C;
	localparam axiAdrs_t regStatus = 8'h10;
	localparam axiAdrs_t regClkDiv = 8'h14;
	localparam axiResp_t respOkay = 2'b00;
	localparam axiResp_t respSlvErr = 2'b10;

	// Lane engine states, one RAM clock per byte
	typedef enum logic [2:0]
	{
		laneIdle,
		laneCmd,
		laneAdrs,
		laneWait,
		laneData,
		laneEnd
	} laneState_t;

	typedef struct packed
	{
		logic write;
		ramAdrs_t adrs;
		ramWord_t wdata;
	} memReq_t;

	// done is a single-cycle pulse, rdByte valid with it
	typedef struct packed
	{
		logic done;
		ramByte_t rdByte;
	} laneResult_t;

endpackage

//--- hw/ramCsr.sv
`timescale 1ns/1ps

module ramCsr
(
	input logic sClk,
	input logic rstN,
	// AXI4-Lite write channels
	input ramPkg::axiAdrs_t awaddr,
	input logic awvalid,
	output logic awready,
	input ramPkg::axiData_t wdata,
	input logic [ramPkg::axiDataWidth/8-1:0] wstrb,
	input logic wvalid,
	output logic wready,
	output ramPkg::axiResp_t bresp,
	output logic bvalid,
	input logic bready,
	// AXI4-Lite read channels
	input ramPkg::axiAdrs_t araddr,
	input logic arvalid,
	output logic arready,
	output ramPkg::axiData_t rdata,
	output ramPkg::axiResp_t rresp,
	output logic rvalid,
	input logic rready,
	// Towards the sequencer and lanes
	output logic start,
	output ramPkg::memReq_t req,
	output ramPkg::clkDiv_t clkDiv,
	input logic busy,
	input logic done,
	input ramPkg::ramWord_t rdWord
);
	import ramPkg::*;

	logic wrAccept;
	logic wrFire;
	logic wrOk;
	logic rdAccept;
	logic rdFire;
	logic rdOk;
	axiData_t rdMux;
	logic writeSel;
	ramAdrs_t adrsReg;
	ramWord_t wdataReg;
	ramWord_t rdataReg;
	logic doneFlag;
	logic pendRead;

	// ------------------------------
	// Handshakes
	// ------------------------------
	// Both write channels present, no response outstanding
	assign wrAccept = awvalid && wvalid && !awready && !bvalid;
	assign wrFire = awready && awvalid;
	assign rdAccept = arvalid && !arready && !rvalid;
	assign rdFire = arready && arvalid;

	assign req = '{write: writeSel, adrs: adrsReg, wdata: wdataReg};

	// Offsets that exist, read-only ones included
	always_comb
	begin
		case (awaddr)
			regCtrl, regAdrs, regWdata, regRdata, regStatus, regClkDiv: wrOk = 1'b1;
			default: wrOk = 1'b0;
		endcase
	end

	// Read data select
	always_comb
	begin
		rdMux = '0;
		rdOk = 1'b1;
		case (araddr)
			regCtrl: rdMux[1] = writeSel;
			regAdrs: rdMux[ramAdrsWidth-1:0] = adrsReg;
			regWdata: rdMux[$bits(ramWord_t)-1:0] = wdataReg;
			regRdata: rdMux[$bits(ramWord_t)-1:0] = rdataReg;
			regStatus: rdMux[1:0] = {doneFlag, busy};
			regClkDiv: rdMux[$bits(clkDiv_t)-1:0] = clkDiv;
			default: rdOk = 1'b0;
		endcase
	end

	always_ff @(posedge sClk or negedge rstN)
	begin
		if (!rstN)
		begin
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
			bresp <= respOkay;
			arready <= 1'b0;
			rvalid <= 1'b0;
			rresp <= respOkay;
			rdata <= '0;
		end
		else
		begin
			// Ready for exactly one cycle
			awready <= wrAccept;
			wready <= wrAccept;
			arready <= rdAccept;
			if (wrFire)
			begin
				bvalid <= 1'b1;
				bresp <= wrOk ? respOkay : respSlvErr;
			end
			else if (bready)
				bvalid <= 1'b0;
			if (rdFire)
			begin
				rvalid <= 1'b1;
				rresp <= rdOk ? respOkay : respSlvErr;
				rdata <= rdMux;
			end
			else if (rready)
				rvalid <= 1'b0;
		end
	end

	// ------------------------------
	// Control and status
	// ------------------------------
	always_ff @(posedge sClk or negedge rstN)
	begin
		if (!rstN)
		begin
			start <= 1'b0;
			writeSel <= 1'b0;
			clkDiv <= clkDivReset;
			doneFlag <= 1'b0;
			pendRead <= 1'b0;
			rdataReg <= '0;
		end
		else
		begin
			// Start is a self-clearing pulse
			start <= 1'b0;
			if (wrFire && awaddr == regCtrl && wstrb[0])
			begin
				start <= wdata[0];
				writeSel <= wdata[1];
			end
			if (wrFire && awaddr == regClkDiv && wstrb[0])
				clkDiv <= wdata[$bits(clkDiv_t)-1:0];
			// Sticky done, cleared only by a start the sequencer takes
			if (done)
				doneFlag <= 1'b1;
			else if (start && !busy)
				doneFlag <= 1'b0;
			// Remember the direction of the access in flight
			if (start && !busy)
				pendRead <= !req.write;
			if (done && pendRead)
				rdataReg <= rdWord;
		end
	end

	// Address and write data, byte strobed
	always_ff @(posedge sClk)
	begin
		if (wrFire && awaddr == regAdrs)
		begin
			if (wstrb[0])
				adrsReg[7:0] <= wdata[7:0];
			if (wstrb[1])
				adrsReg[15:8] <= wdata[15:8];
			if (wstrb[2])
				adrsReg[ramAdrsWidth-1:16] <= wdata[ramAdrsWidth-1:16];
		end
		if (wrFire && awaddr == regWdata)
		begin
			if (wstrb[0])
				wdataReg[7:0] <= wdata[7:0];
			if (wstrb[1])
				wdataReg[15:8] <= wdata[15:8];
		end
	end

endmodule

//--- hw/memAccessSeq.sv
`timescale 1ns/1ps

module memAccessSeq
(
	input logic sClk,
	input logic rstN,
	input logic start,
	input ramPkg::memReq_t reqIn,
	output ramPkg::memReq_t reqOut,
	output logic reqValid,
	input logic [ramPkg::laneCount-1:0] laneReady,
	input logic done,
	output logic busy
);

	// Idle, offer to lanes, wait for the collector
	typedef enum logic [1:0]
	{
		seqIdle,
		seqIssue,
		seqWait
	} seqState_t;

	seqState_t state;

	// ------------------------------
	// Request FSM
	// ------------------------------
	always_ff @(posedge sClk or negedge rstN)
	begin
		if (!rstN)
			state <= seqIdle;
		else
		begin
			case (state)
				seqIdle:
				begin
					// Starts outside idle are dropped
					if (start)
						state <= seqIssue;
				end
				seqIssue:
				begin
					// Every lane takes it in this cycle
					if (&laneReady)
						state <= seqWait;
				end
				seqWait:
				begin
					if (done)
						state <= seqIdle;
				end
				default:
					state <= seqIdle;
			endcase
		end
	end

	// Snapshot of the registers at start, stable until next start
	always_ff @(posedge sClk)
	begin
		if (state == seqIdle && start)
			reqOut <= reqIn;
	end

	assign reqValid = (state == seqIssue);
	// Busy from issue until the merged done
	assign busy = (state != seqIdle);

endmodule

//--- hw/psramLane.sv
`timescale 1ns/1ps

module psramLane
(
	input logic sClk,
	input logic rstN,
	input ramPkg::memReq_t req,
	input logic reqValid,
	output logic reqReady,
	input logic laneSel,
	input ramPkg::clkDiv_t clkDiv,
	output ramPkg::ramByte_t dqOut,
	input ramPkg::ramByte_t dqIn,
	output logic dqOe,
	output logic ramClk,
	output logic ramCeN,
	output ramPkg::laneResult_t result
);
	import ramPkg::*;

	laneState_t state;
	clkDiv_t divCnt;
	logic [2:0] byteCnt;
	logic isWrite;
	logic [frameBytes*laneWidth-1:0] txShift;
	ramByte_t wrByte;
	ramByte_t rdByteQ;
	logic doneQ;
	logic halfEnd;
	logic clkActive;
	logic clkRise;
	logic clkFall;

	// ------------------------------
	// RAM clock timing
	// ------------------------------
	// Half period is clkDiv+1 sClk cycles
	assign halfEnd = (divCnt >= clkDiv);
	assign clkActive = state inside {laneCmd, laneAdrs, laneWait, laneData};
	assign clkRise = clkActive && halfEnd && !ramClk;
	assign clkFall = clkActive && halfEnd && ramClk;

	assign reqReady = (state == laneIdle);
	// This chip's half of the word
	assign wrByte = req.wdata[laneSel*laneWidth +: laneWidth];
	// Top byte of the frame is on the pins
	assign dqOut = txShift[frameBytes*laneWidth-1 -: laneWidth];
	assign result = '{done: doneQ, rdByte: rdByteQ};

	always_ff @(posedge sClk or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= laneIdle;
			divCnt <= '0;
			byteCnt <= '0;
			ramClk <= 1'b0;
			ramCeN <= 1'b1;
			dqOe <= 1'b0;
			doneQ <= 1'b0;
		end
		else
		begin
			doneQ <= 1'b0;
			divCnt <= halfEnd ? '0 : divCnt + 1'b1;
			if (clkActive && halfEnd)
				ramClk <= ~ramClk;
			case (state)
				laneIdle:
				begin
					// Chip select low, command byte out in the first low phase
					if (reqValid)
					begin
						state <= laneCmd;
						divCnt <= '0;
						byteCnt <= '0;
						ramCeN <= 1'b0;
						dqOe <= 1'b1;
					end
				end
				laneCmd:
				begin
					if (clkFall)
						state <= laneAdrs;
				end
				laneAdrs:
				begin
					if (clkFall)
					begin
						if (byteCnt == adrsBytes - 1)
						begin
							byteCnt <= '0;
							if (isWrite)
								state <= laneData;
							else
							begin
								// Turn the bus around
								state <= laneWait;
								dqOe <= 1'b0;
							end
						end
						else
							byteCnt <= byteCnt + 1'b1;
					end
				end
				laneWait:
				begin
					// Dummy clocks
					if (clkFall)
					begin
						if (byteCnt == readWaitClks - 1)
						begin
							byteCnt <= '0;
							state <= laneData;
						end
						else
							byteCnt <= byteCnt + 1'b1;
					end
				end
				laneData:
				begin
					if (clkFall)
					begin
						state <= laneEnd;
						ramCeN <= 1'b1;
						dqOe <= 1'b0;
					end
				end
				laneEnd:
				begin
					// CE high for a half period, then report
					if (halfEnd)
					begin
						state <= laneIdle;
						doneQ <= 1'b1;
					end
				end
				default:
					state <= laneIdle;
			endcase
		end
	end

	// ------------------------------
	// Frame shifter and read capture
	// ------------------------------
	always_ff @(posedge sClk)
	begin
		if (reqReady && reqValid)
		begin
			isWrite <= req.write;
			txShift <= {req.write ? cmdWrite : cmdRead,
				{(adrsBytes*laneWidth-ramAdrsWidth){1'b0}}, req.adrs, wrByte};
		end
		else if (clkFall)
			txShift <= txShift << laneWidth;
		// Sample as ramClk rises
		if (clkRise && state == laneData && !isWrite)
			rdByteQ <= dqIn;
	end

endmodule

//--- hw/readCollector.sv
`timescale 1ns/1ps

module readCollector
(
	input logic sClk,
	input logic rstN,
	input ramPkg::laneResult_t results [ramPkg::laneCount],
	output ramPkg::ramWord_t rdWord,
	output logic done
);
	import ramPkg::*;

	logic [laneCount-1:0] finished;
	logic [laneCount-1:0] laneDone;
	ramByte_t byteReg [laneCount];

	// Lane 0 is the low byte
	always_comb
	begin
		for (int i = 0; i < laneCount; i++)
		begin
			laneDone[i] = results[i].done;
			rdWord[i*laneWidth +: laneWidth] = byteReg[i];
		end
	end

	// ------------------------------
	// Finish mask
	// ------------------------------
	always_ff @(posedge sClk or negedge rstN)
	begin
		if (!rstN)
		begin
			finished <= '0;
			done <= 1'b0;
		end
		else if (&(finished | laneDone))
		begin
			// Last lane in, pulse next cycle
			finished <= '0;
			done <= 1'b1;
		end
		else
		begin
			finished <= finished | laneDone;
			done <= 1'b0;
		end
	end

	// Byte capture per lane
	always_ff @(posedge sClk)
	begin
		for (int i = 0; i < laneCount; i++)
		begin
			if (laneDone[i])
				byteReg[i] <= results[i].rdByte;
		end
	end

endmodule

//--- hw/ramBlock.sv
`timescale 1ns/1ps

module ramBlock
(
	input logic sClk,
	input logic rstN,
	// AXI4-Lite slave
	input ramPkg::axiAdrs_t awaddr,
	input logic awvalid,
	output logic awready,
	input ramPkg::axiData_t wdata,
	input logic [ramPkg::axiDataWidth/8-1:0] wstrb,
	input logic wvalid,
	output logic wready,
	output ramPkg::axiResp_t bresp,
	output logic bvalid,
	input logic bready,
	input ramPkg::axiAdrs_t araddr,
	input logic arvalid,
	output logic arready,
	output ramPkg::axiData_t rdata,
	output ramPkg::axiResp_t rresp,
	output logic rvalid,
	input logic rready,
	// PSRAM pins, one byte slice per chip
	output wire ramPkg::ramWord_t ramDq,
	input ramPkg::ramWord_t ramDqIn,
	output wire [ramPkg::laneCount-1:0] ramDqOe,
	output wire [ramPkg::laneCount-1:0] ramClk,
	output wire [ramPkg::laneCount-1:0] ramCeN
);
	import ramPkg::*;

	logic start;
	logic busy;
	logic done;
	logic reqValid;
	memReq_t csrReq;
	memReq_t laneReq;
	clkDiv_t clkDiv;
	ramWord_t rdWord;
	wire [laneCount-1:0] laneReady;
	laneResult_t laneRes [laneCount];

	// ------------------------------
	// Register slave
	// ------------------------------
	ramCsr ramCsr
	(
		.sClk(sClk),			.rstN(rstN),
		.awaddr(awaddr),		.awvalid(awvalid),		.awready(awready),
		.wdata(wdata),			.wstrb(wstrb),
		.wvalid(wvalid),		.wready(wready),
		.bresp(bresp),			.bvalid(bvalid),		.bready(bready),
		.araddr(araddr),		.arvalid(arvalid),		.arready(arready),
		.rdata(rdata),			.rresp(rresp),
		.rvalid(rvalid),		.rready(rready),
		.start(start),			.req(csrReq),			.clkDiv(clkDiv),
		.busy(busy),			.done(done),			.rdWord(rdWord)
	);

	// One request to all lanes
	memAccessSeq memAccessSeq
	(
		.sClk(sClk),			.rstN(rstN),
		.start(start),			.reqIn(csrReq),
		.reqOut(laneReq),		.reqValid(reqValid),
		.laneReady(laneReady),	.done(done),			.busy(busy)
	);

	// ------------------------------
	// Lane per chip
	// ------------------------------
	for (genvar i = 0; i < laneCount; i++)
	begin : gLane
		psramLane psramLane
		(
			.sClk(sClk),			.rstN(rstN),
			.req(laneReq),			.reqValid(reqValid),
			.reqReady(laneReady[i]),
			.laneSel(1'(i)),		.clkDiv(clkDiv),
			.dqOut(ramDq[i*laneWidth +: laneWidth]),
			.dqIn(ramDqIn[i*laneWidth +: laneWidth]),
			.dqOe(ramDqOe[i]),		.ramClk(ramClk[i]),
			.ramCeN(ramCeN[i]),		.result(laneRes[i])
		);
	end

	// Byte merge and completion
	readCollector readCollector
	(
		.sClk(sClk),			.rstN(rstN),
		.results(laneRes),		.rdWord(rdWord),		.done(done)
	);

endmodule

//--- tb/psramModel.sv
`timescale 1ns/1ps

module psramModel
#(
	// Mixed into the fill pattern so the two chips differ
	parameter ramPkg::ramByte_t fillKey = 8'h00
)
(
	input logic ramClk,
	input logic ceN,
	input logic oe,
	input ramPkg::ramByte_t dqIn,
	output ramPkg::ramByte_t dqOut,
	output logic [23:0] lastAdrs,
	output ramPkg::ramByte_t lastByte,
	output logic badCmd,
	output logic badOe
);
	import ramPkg::*;

	localparam int tableSize = 64;

	// Written bytes where the newest entry wins
	logic [23:0] tblAdrs [tableSize];
	ramByte_t tblData [tableSize];
	int tblCount = 0;
	int edgeCnt = 0;
	ramByte_t cmd;
	logic [23:0] adrs;
	ramByte_t rdByte;
	logic badCmdQ = 1'b0;
	logic badOeQ = 1'b0;

	// Unwritten cells return a pattern of the full address
	function automatic ramByte_t fetch(input logic [23:0] a);
		ramByte_t v;
		v = a[7:0] ^ a[15:8] ^ a[23:16] ^ fillKey;
		for (int i = 0; i < tblCount; i++)
		begin
			if (tblAdrs[i] == a)
				v = tblData[i];
		end
		return v;
	endfunction

	// ------------------------------
	// Frame decode on rising ramClk
	// ------------------------------
	always @(posedge ramClk or posedge ceN)
	begin
		if (ceN)
			edgeCnt <= 0;
		else
		begin
			edgeCnt <= edgeCnt + 1;
			// Host owns the bus for command, address and write data
			if (!oe && (edgeCnt < 4 || (edgeCnt == 4 && cmd == cmdWrite)))
				badOeQ <= 1'b1;
			case (edgeCnt)
				0:
					cmd <= dqIn;
				1:
				begin
					// Address MSB first
					adrs[23:16] <= dqIn;
					if (cmd != cmdWrite && cmd != cmdRead)
						badCmdQ <= 1'b1;
				end
				2:
					adrs[15:8] <= dqIn;
				3:
				begin
					adrs[7:0] <= dqIn;
					// Read data ready well before the dummy clocks end
					rdByte <= fetch({adrs[23:8], dqIn});
				end
				4:
				begin
					if (cmd == cmdWrite)
					begin
						tblAdrs[tblCount] <= adrs;
						tblData[tblCount] <= dqIn;
						tblCount <= tblCount + 1;
						lastAdrs <= adrs;
						lastByte <= dqIn;
					end
				end
				default:
					;
			endcase
		end
	end

	// Drive back only while the host has released the bus
	assign dqOut = oe ? 'z : rdByte;
	assign badCmd = badCmdQ;
	assign badOe = badOeQ;

endmodule

//--- tb/tbRamBlock.sv
`timescale 1ns/1ps

module tbRamBlock;
	import ramPkg::*;

	localparam int halfPeriod = 10;
	localparam int resetCycles = 5;
	localparam int pairCount = 20;
	// 40 accesses of up to 9 RAM clocks at divider 3 plus AXI polling and margin
	localparam int timeoutCycles = 30000;
	localparam logic [laneCount-1:0][7:0] fillKey = {8'hA5, 8'h3C};
	localparam int shadowSize = 64;

	logic sClk;
	logic rstN;
	axiAdrs_t awaddr;
	logic awvalid;
	logic awready;
	axiData_t wdata;
	logic [axiDataWidth/8-1:0] wstrb;
	logic wvalid;
	logic wready;
	axiResp_t bresp;
	logic bvalid;
	logic bready;
	axiAdrs_t araddr;
	logic arvalid;
	logic arready;
	axiData_t rdata;
	axiResp_t rresp;
	logic rvalid;
	logic rready;
	wire [15:0] ramDq;
	wire [15:0] ramDqIn;
	wire [laneCount-1:0] ramDqOe;
	wire [laneCount-1:0] ramClk;
	wire [laneCount-1:0] ramCeN;
	wire [laneCount-1:0][23:0] lastAdrs;
	wire [laneCount-1:0][7:0] lastByte;
	wire [laneCount-1:0] badCmd;
	wire [laneCount-1:0] badOe;

	logic [31:0] lcgState = 32'h5616_d1eb;
	clkDiv_t curDiv;
	int cycleCount = 0;
	int highCnt [laneCount];
	// Pending checks drained by the compare process
	string nameQ [$];
	logic [31:0] expQ [$];
	logic [31:0] actQ [$];
	string chkName;
	logic [31:0] chkExp;
	logic [31:0] chkAct;
	ramAdrs_t shAdrs [shadowSize];
	ramWord_t shData [shadowSize];
	int shCount = 0;

	ramBlock i_dut
	(
		.sClk(sClk),		.rstN(rstN),
		.awaddr(awaddr),	.awvalid(awvalid),	.awready(awready),
		.wdata(wdata),		.wstrb(wstrb),		.wvalid(wvalid),	.wready(wready),
		.bresp(bresp),		.bvalid(bvalid),	.bready(bready),
		.araddr(araddr),	.arvalid(arvalid),	.arready(arready),
		.rdata(rdata),		.rresp(rresp),		.rvalid(rvalid),	.rready(rready),
		.ramDq(ramDq),		.ramDqIn(ramDqIn),	.ramDqOe(ramDqOe),
		.ramClk(ramClk),	.ramCeN(ramCeN)
	);

	// One chip per byte slice
	for (genvar g = 0; g < laneCount; g++)
	begin : gChip
		psramModel #(.fillKey(fillKey[g])) model
		(
			.ramClk(ramClk[g]),		.ceN(ramCeN[g]),		.oe(ramDqOe[g]),
			.dqIn(ramDq[g*laneWidth +: laneWidth]),
			.dqOut(ramDqIn[g*laneWidth +: laneWidth]),
			.lastAdrs(lastAdrs[g]),	.lastByte(lastByte[g]),	.badCmd(badCmd[g]),
			.badOe(badOe[g])
		);
	end

	initial
		sClk = 1'b0;
	always #halfPeriod sClk = ~sClk;

	// ------------------------------
	// Helpers
	// ------------------------------
	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic ramByte_t fillByte(input ramAdrs_t a, input int lane);
		return a[7:0] ^ a[15:8] ^ {1'b0, a[22:16]} ^ fillKey[lane];
	endfunction

	// Shadow memory lookup where the newest write wins
	function automatic ramWord_t expectedWord(input ramAdrs_t a);
		ramWord_t w;
		w = {fillByte(a, 1), fillByte(a, 0)};
		for (int i = 0; i < shCount; i++)
		begin
			if (shAdrs[i] == a)
				w = shData[i];
		end
		return w;
	endfunction

	task automatic shadowWrite(input ramAdrs_t a, input ramWord_t d);
		shAdrs[shCount] = a;
		shData[shCount] = d;
		shCount++;
	endtask

	task automatic expectValue(input string name, input logic [31:0] exp, input logic [31:0] act);
		nameQ.push_back(name);
		expQ.push_back(exp);
		actQ.push_back(act);
	endtask

	task automatic abortRun(input string msg);
		$display("%s", msg);
		$display("TESTS FAILED");
		$fatal(1, "Run aborted");
	endtask

	task automatic axiWrite(input axiAdrs_t adrs, input axiData_t data, output axiResp_t resp);
		@(posedge sClk);
		#1;
		awaddr = adrs;
		awvalid = 1'b1;
		wdata = data;
		wstrb = '1;
		wvalid = 1'b1;
		bready = 1'b1;
		@(posedge sClk);
		while (!(awready && wready))
			@(posedge sClk);
		#1;
		awvalid = 1'b0;
		wvalid = 1'b0;
		@(posedge sClk);
		while (!bvalid)
			@(posedge sClk);
		resp = bresp;
		#1;
		bready = 1'b0;
	endtask

	task automatic axiRead(input axiAdrs_t adrs, output axiData_t data, output axiResp_t resp);
		@(posedge sClk);
		#1;
		araddr = adrs;
		arvalid = 1'b1;
		rready = 1'b1;
		@(posedge sClk);
		while (!arready)
			@(posedge sClk);
		#1;
		arvalid = 1'b0;
		@(posedge sClk);
		while (!rvalid)
			@(posedge sClk);
		data = rdata;
		resp = rresp;
		#1;
		rready = 1'b0;
	endtask

	task automatic regWrite(input axiAdrs_t adrs, input axiData_t data);
		axiResp_t resp;
		axiWrite(adrs, data, resp);
		expectValue("bresp", respOkay, resp);
	endtask

	task automatic regRead(input axiAdrs_t adrs, output axiData_t data);
		axiResp_t resp;
		axiRead(adrs, data, resp);
		expectValue("rresp", respOkay, resp);
	endtask

	// Poll STATUS until the sticky done bit shows
	task automatic waitDone();
		axiData_t st;
		st = '0;
		while (!st[1])
			regRead(regStatus, st);
	endtask

	task automatic setDivider(input clkDiv_t div);
		regWrite(regClkDiv, div);
		curDiv = div;
	endtask

	task automatic memWrite(input ramAdrs_t adrs, input ramWord_t data);
		regWrite(regAdrs, adrs);
		regWrite(regWdata, data);
		regWrite(regCtrl, 32'h3);
		waitDone();
		shadowWrite(adrs, data);
		// Lane 0 holds the low byte and lane 1 the high byte
		for (int i = 0; i < laneCount; i++)
		begin
			expectValue($sformatf("chip%0dAdrs", i), {1'b0, adrs}, lastAdrs[i]);
			expectValue($sformatf("chip%0dByte", i), data[i*laneWidth +: laneWidth], lastByte[i]);
		end
	endtask

	task automatic memRead(input ramAdrs_t adrs, output axiData_t data);
		regWrite(regAdrs, adrs);
		regWrite(regCtrl, 32'h1);
		waitDone();
		regRead(regRdata, data);
	endtask

	// ------------------------------
	// Compare, monitor, timeout
	// ------------------------------
	always @(posedge sClk)
	begin
		while (nameQ.size() > 0)
		begin
			chkName = nameQ.pop_front();
			chkExp = expQ.pop_front();
			chkAct = actQ.pop_front();
			assert (chkAct === chkExp)
			else
				abortRun($sformatf("Mismatch %s expected %h actual %h", chkName, chkExp, chkAct));
		end
	end

	always @(posedge sClk)
	begin
		cycleCount++;
		assert (cycleCount < timeoutCycles)
		else
			abortRun($sformatf("Timeout after %0d cycles, an access never finished", cycleCount));
		assert (badCmd === '0)
		else
			abortRun("A PSRAM model decoded an unknown command byte");
		assert (badOe === '0)
		else
			abortRun("The DUT released the PSRAM data bus while sending a frame");
		// Width of each ramClk high phase in sClk cycles
		for (int i = 0; i < laneCount; i++)
		begin
			if (!ramCeN[i] && ramClk[i])
				highCnt[i]++;
			else if (highCnt[i] != 0)
			begin
				expectValue($sformatf("ramClkHigh%0d", i), curDiv + 1, highCnt[i]);
				highCnt[i] = 0;
			end
		end
	end

	// ------------------------------
	// Stimulus
	// ------------------------------
	initial
	begin
		logic [31:0] rnd;
		ramAdrs_t adrs;
		ramAdrs_t adrs2;
		ramWord_t data;
		ramWord_t data2;
		axiData_t rd;
		axiData_t lastRdata;
		axiResp_t resp;
		rstN = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		curDiv = clkDivReset;
		lastRdata = '0;
		repeat (resetCycles) @(posedge sClk);
		#1;
		rstN = 1'b1;

		// Reset values
		regRead(regStatus, rd);
		expectValue("resetStatus", 32'h0, rd);
		regRead(regClkDiv, rd);
		expectValue("resetClkDiv", clkDivReset, rd);
		regRead(regRdata, rd);
		expectValue("resetRdata", 32'h0, rd);

		// Random write then read at a random divider
		for (int n = 0; n < pairCount; n++)
		begin
			rnd = nextRand();
			adrs = rnd[31:9];
			rnd = nextRand();
			data = rnd[31:16];
			rnd = nextRand();
			setDivider(rnd[31:30]);
			memWrite(adrs, data);
			memRead(adrs, rd);
			expectValue("readBack", expectedWord(adrs), rd);
			lastRdata = expectedWord(adrs);
		end

		// Unmapped offsets and the read-only RDATA
		axiRead(8'h18, rd, resp);
		expectValue("unmappedReadResp", respSlvErr, resp);
		axiWrite(8'h1C, 32'h1234, resp);
		expectValue("unmappedWriteResp", respSlvErr, resp);
		regWrite(regRdata, ~lastRdata);
		regRead(regRdata, rd);
		expectValue("rdataWriteIgnored", lastRdata, rd);

		// Second start while busy is dropped
		setDivider(8'd3);
		rnd = nextRand();
		adrs = rnd[31:9];
		rnd = nextRand();
		adrs2 = rnd[31:9];
		if (adrs2 == adrs)
			adrs2 = adrs2 + 1'b1;
		rnd = nextRand();
		data = rnd[31:16];
		data2 = rnd[15:0];
		regWrite(regAdrs, adrs);
		regWrite(regWdata, data);
		regWrite(regCtrl, 32'h3);
		regWrite(regAdrs, adrs2);
		regWrite(regWdata, data2);
		regWrite(regCtrl, 32'h3);
		regRead(regStatus, rd);
		expectValue("busyAtSecondStart", 32'h1, rd[0]);
		waitDone();
		shadowWrite(adrs, data);
		memRead(adrs2, rd);
		expectValue("droppedStart", expectedWord(adrs2), rd);
		memRead(adrs, rd);
		expectValue("firstStart", expectedWord(adrs), rd);

		// Let the compare process drain
		while (nameQ.size() > 0)
			@(posedge sClk);
		@(posedge sClk);
		$display("TESTS PASSED");
		$finish;
	end

endmodule

//--- files.f
hw/ramPkg.sv
hw/ramCsr.sv
hw/memAccessSeq.sv
hw/psramLane.sv
hw/readCollector.sv
hw/ramBlock.sv
tb/psramModel.sv
tb/tbRamBlock.sv

//--- Bender.yml
package:
  name: ram_block

sources:
  - hw/ramPkg.sv
  - hw/ramCsr.sv
  - hw/memAccessSeq.sv
  - hw/psramLane.sv
  - hw/readCollector.sv
  - hw/ramBlock.sv
  - target: simulation
    files:
      - tb/psramModel.sv
      - tb/tbRamBlock.sv
